//--- common/wb_pkg.sv
package wb_pkg;

    // reorder buffer size, the index space every writeback is tagged with
    localparam int ROB_DEPTH = 16;
    localparam int ROB_ID_W  = $clog2(ROB_DEPTH);

    // width of one result value
    localparam int DATA_W = 32;

    // execution ports feeding the common data bus
    localparam int CDB_PORT_CNT = 4;

    // reorder buffer index, bit 0 picks the bank
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    typedef logic [DATA_W-1:0] wb_data_t;

    // one result on the common data bus
    typedef struct packed {
        logic     valid;
        rob_id_t  wid;
        wb_data_t data;
    } cdb_t;

endpackage

//--- common/rob_pkg.sv
package rob_pkg;

    // the buffer is split in two banks by the low index bit
    localparam int BANK_CNT   = 2;
    localparam int BANK_DEPTH = wb_pkg::ROB_DEPTH / BANK_CNT;

    // row inside a bank, the index with bit 0 dropped
    typedef logic [$clog2(BANK_DEPTH)-1:0] bank_idx_t;

    // one stored entry as the commit side sees it
    typedef struct packed {
        logic             done;
        wb_pkg::wb_data_t data;
    } rob_entry_t;

    // one retire lane
    typedef struct packed {
        logic             valid;
        wb_pkg::rob_id_t  wid;
        wb_pkg::wb_data_t data;
    } retire_t;

endpackage

//--- hw/cdb_arb/cdb_arb.sv
`timescale 1ns/10ps

// routes execution port results to the two reorder buffer banks
module cdb_arb #(
    parameter int PORT_CNT = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  wb_pkg::cdb_t [PORT_CNT-1:0] cdb_i,
    output logic [PORT_CNT-1:0]         ready_o,
    output wb_pkg::cdb_t [1:0]          bank_wr_o
);

    // a refused writeback parks here and is replayed ahead of any new input
    wb_pkg::cdb_t [PORT_CNT-1:0] skid_q;

    // request seen by the arbiter on each port this cycle
    wb_pkg::cdb_t [PORT_CNT-1:0] req;
    logic [PORT_CNT-1:0]         grant;

    // winner per bank before the output register
    wb_pkg::cdb_t [1:0] sel;

    for (genvar i = 0; i < PORT_CNT; i++) begin : g_req
        assign req[i]     = skid_q[i].valid ? skid_q[i] : cdb_i[i];
        assign ready_o[i] = !skid_q[i].valid;
    end

    // fixed priority per bank, the lowest numbered port takes the lane
    // and every later port aiming at the same bank is refused
    always_comb begin
        grant = '0;
        sel   = '0;
        for (int i = 0; i < PORT_CNT; i++) begin
            if (req[i].valid && !sel[req[i].wid[0]].valid) begin
                grant[i]           = 1'b1;
                sel[req[i].wid[0]] = req[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PORT_CNT; i++) begin
                skid_q[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < PORT_CNT; i++) begin
                if (grant[i]) begin
                    // replay or fresh input went out, the port is free again
                    skid_q[i].valid <= 1'b0;
                end else if (!skid_q[i].valid && cdb_i[i].valid) begin
                    skid_q[i] <= cdb_i[i];
                end
            end
        end
    end

    // winners reach the banks one clock after they are granted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_wr_o[0].valid <= 1'b0;
            bank_wr_o[1].valid <= 1'b0;
        end else begin
            bank_wr_o <= sel;
        end
    end

    // two ports never carry the same reorder buffer index at once
    for (genvar i = 0; i < PORT_CNT; i++) begin : g_dup_chk
        for (genvar j = i + 1; j < PORT_CNT; j++) begin : g_pair
            a_unique_wid: assert property (@(posedge clk) disable iff (!rst_n)
                req[i].valid && req[j].valid |-> req[i].wid != req[j].wid);
        end
    end

    // while the skid is full the port must keep its pending writeback unchanged
    for (genvar i = 0; i < PORT_CNT; i++) begin : g_port_chk
        a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
            !ready_o[i] && cdb_i[i].valid |=> $stable(cdb_i[i]));
    end

endmodule

//--- hw/rob/rob_bank.sv
`timescale 1ns/10ps

// one reorder buffer bank, completion flags plus result data
module rob_bank (
    input  logic                          clk,
    input  logic                          rst_n,
    input  wb_pkg::cdb_t                  wr_i,
    input  logic                          clr_i,
    input  rob_pkg::bank_idx_t            clr_idx_i,
    input  rob_pkg::bank_idx_t [1:0]      rd_idx_i,
    output rob_pkg::rob_entry_t [1:0]     rd_o
);

    logic [rob_pkg::BANK_DEPTH-1:0] done_q;
    wb_pkg::wb_data_t               data_q [rob_pkg::BANK_DEPTH];

    // the lane already guarantees bit 0, the rest of the index is the row
    rob_pkg::bank_idx_t wr_idx;

    assign wr_idx = rob_pkg::bank_idx_t'(wr_i.wid >> 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            // allocation and writeback never address the same live row
            if (clr_i) begin
                done_q[clr_idx_i] <= 1'b0;
            end
            if (wr_i.valid) begin
                done_q[wr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.valid) begin
            data_q[wr_idx] <= wr_i.data;
        end
    end

    // reads are from the registers, so a write shows up the following cycle
    for (genvar p = 0; p < 2; p++) begin : g_rd
        assign rd_o[p] = '{done: done_q[rd_idx_i[p]], data: data_q[rd_idx_i[p]]};
    end

    // each allocated entry is written exactly once before it retires
    a_no_double_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_i.valid |-> !done_q[wr_idx]);

endmodule

//--- hw/rob/rob_commit.sv
`timescale 1ns/10ps

// allocation pointer, retire pointer and the two wide in-order retire
module rob_commit (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 alloc_i,
    output logic                                                 alloc_ready_o,
    output wb_pkg::rob_id_t                                      alloc_wid_o,
    output logic [rob_pkg::BANK_CNT-1:0]                         clr_o,
    output rob_pkg::bank_idx_t                                   clr_idx_o,
    output rob_pkg::bank_idx_t [rob_pkg::BANK_CNT-1:0][1:0]      rd_idx_o,
    input  rob_pkg::rob_entry_t [rob_pkg::BANK_CNT-1:0][1:0]     rd_i,
    output rob_pkg::retire_t [1:0]                               retire_o
);

    // occupancy has to reach the full depth, hence one extra bit
    typedef logic [$clog2(wb_pkg::ROB_DEPTH):0] count_t;

    wb_pkg::rob_id_t     head_q;
    wb_pkg::rob_id_t     tail_q;
    count_t              count_q;
    wb_pkg::rob_id_t     head_p1;
    rob_pkg::bank_idx_t  head_row;
    rob_pkg::rob_entry_t ent0;
    rob_pkg::rob_entry_t ent1;
    logic                alloc_fire;
    logic                ret0;
    logic                ret1;
    logic [1:0]          ret_cnt;

    assign alloc_ready_o = count_q != count_t'(wb_pkg::ROB_DEPTH);
    assign alloc_wid_o   = tail_q;
    assign alloc_fire    = alloc_i && alloc_ready_o;

    // a fresh allocation clears the done flag in the tail's bank
    always_comb begin
        clr_o            = '0;
        clr_o[tail_q[0]] = alloc_fire;
    end
    assign clr_idx_o = rob_pkg::bank_idx_t'(tail_q >> 1);

    // port 0 of both banks reads the head row, port 1 the row after it
    // head plus one sits in the other bank, on the next row when the head is odd
    assign head_row = rob_pkg::bank_idx_t'(head_q >> 1);
    assign head_p1  = head_q + 1'b1;

    for (genvar b = 0; b < rob_pkg::BANK_CNT; b++) begin : g_rd_idx
        assign rd_idx_o[b][0] = head_row;
        assign rd_idx_o[b][1] = rob_pkg::bank_idx_t'(head_row + 1'b1);
    end

    assign ent0 = rd_i[head_q[0]][0];
    assign ent1 = head_q[0] ? rd_i[0][1] : rd_i[1][0];

    // the second lane only retires behind the first
    assign ret0    = (count_q != '0) && ent0.done;
    assign ret1    = ret0 && (count_q >= count_t'(2)) && ent1.done;
    assign ret_cnt = {1'b0, ret0} + {1'b0, ret1};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q             <= '0;
            tail_q             <= '0;
            count_q            <= '0;
            retire_o[0].valid  <= 1'b0;
            retire_o[1].valid  <= 1'b0;
        end else begin
            if (alloc_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            head_q      <= head_q + wb_pkg::rob_id_t'(ret_cnt);
            count_q     <= count_q + count_t'(alloc_fire) - count_t'(ret_cnt);
            retire_o[0] <= '{valid: ret0, wid: head_q, data: ent0.data};
            retire_o[1] <= '{valid: ret1, wid: head_p1, data: ent1.data};
        end
    end

    // a retiring head is an allocated entry, so head and tail differ unless the buffer is full
    a_retire_occupied: assert property (@(posedge clk) disable iff (!rst_n)
        ret0 |-> head_q != tail_q || !alloc_ready_o);

endmodule

//--- hw/wb_top.sv
`timescale 1ns/10ps

// writeback and completion path, arbiter feeding two banks and the commit logic
module wb_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  wb_pkg::cdb_t [wb_pkg::CDB_PORT_CNT-1:0]    cdb_i,
    output logic [wb_pkg::CDB_PORT_CNT-1:0]            ready_o,
    input  logic                                       alloc_i,
    output logic                                       alloc_ready_o,
    output wb_pkg::rob_id_t                            alloc_wid_o,
    output rob_pkg::retire_t [1:0]                     retire_o
);

    wb_pkg::cdb_t [rob_pkg::BANK_CNT-1:0]                   bank_wr;
    logic [rob_pkg::BANK_CNT-1:0]                           bank_clr;
    rob_pkg::bank_idx_t                                     clr_idx;
    rob_pkg::bank_idx_t [rob_pkg::BANK_CNT-1:0][1:0]        rd_idx;
    rob_pkg::rob_entry_t [rob_pkg::BANK_CNT-1:0][1:0]       rd_ent;

    cdb_arb #(
        .PORT_CNT (wb_pkg::CDB_PORT_CNT)
    ) i_cdb_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .cdb_i     (cdb_i),
        .ready_o   (ready_o),
        .bank_wr_o (bank_wr)
    );

    // bank b holds the entries whose index has bit 0 equal to b
    for (genvar b = 0; b < rob_pkg::BANK_CNT; b++) begin : g_bank
        rob_bank i_rob_bank (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_i      (bank_wr[b]),
            .clr_i     (bank_clr[b]),
            .clr_idx_i (clr_idx),
            .rd_idx_i  (rd_idx[b]),
            .rd_o      (rd_ent[b])
        );
    end

    rob_commit i_rob_commit (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_i       (alloc_i),
        .alloc_ready_o (alloc_ready_o),
        .alloc_wid_o   (alloc_wid_o),
        .clr_o         (bank_clr),
        .clr_idx_o     (clr_idx),
        .rd_idx_o      (rd_idx),
        .rd_i          (rd_ent),
        .retire_o      (retire_o)
    );

endmodule

//--- test/clk_gen.sv
`timescale 1ns/10ps

// free running testbench clock and a reset held low for the first cycles
module clk_gen #(
    parameter real PERIOD     = 40.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // release on a falling edge so the first active edge sees a settled reset
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- test/wb_tb.sv
`timescale 1ns/10ps

module wb_tb;

    localparam int          PORTS   = wb_pkg::CDB_PORT_CNT;
    localparam int          TBL_LEN = 64;
    localparam int          DIR_LEN = 20;
    localparam int          TIMEOUT = TBL_LEN * 8 + 100;
    localparam logic [31:0] SEED    = 32'h901e_ce8f;

    // one stimulus row, the offset picks an entry from the list of unwritten indices
    typedef struct packed {
        logic            alloc;
        logic [3:0]      vld;
        logic [3:0][1:0] off;
    } row_t;

    logic                     clk;
    logic                     rst_n;
    wb_pkg::cdb_t [PORTS-1:0] cdb;
    logic [PORTS-1:0]         ready;
    logic                     alloc;
    logic                     alloc_ready;
    wb_pkg::rob_id_t          alloc_wid;
    rob_pkg::retire_t [1:0]   retire;

    row_t                         tbl [TBL_LEN];
    wb_pkg::cdb_t [PORTS-1:0]     drv;
    wb_pkg::cdb_t [PORTS-1:0]     held;
    logic [PORTS-1:0]             take;
    logic [PORTS-1:0]             exp_ready;
    wb_pkg::rob_id_t              alloc_q [$];
    wb_pkg::rob_id_t              pending [$];
    wb_pkg::wb_data_t             exp_data [wb_pkg::ROB_DEPTH];
    logic [wb_pkg::ROB_DEPTH-1:0] written;
    wb_pkg::rob_id_t              tail;
    int value_errs  = 0;
    int other_errs  = 0;
    int retired     = 0;
    int stalls      = 0;
    int cycles      = 0;

    clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    wb_top i_wb_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cdb_i         (cdb),
        .ready_o       (ready),
        .alloc_i       (alloc),
        .alloc_ready_o (alloc_ready),
        .alloc_wid_o   (alloc_wid),
        .retire_o      (retire)
    );

    // fill the buffer, write one young entry early, then crowd bank 0
    function automatic row_t directed_row(input int r);
        case (r)
            6:       directed_row = 13'b1_0001_00000011;
            18:      directed_row = 13'b1_1111_00000000;
            19:      directed_row = 13'b0_1010_11001000;
            default: directed_row = 13'b1_0000_00000000;
        endcase
    endfunction

    function automatic row_t random_row();
        row_t row;
        row       = row_t'(13'($urandom));
        row.alloc = ($urandom % 4) != 0;
        return row;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        value_errs++;
        $display("error %0t %s expected %0h actual %0h", $time, name, exp, act);
    endtask

    // retire lanes must follow allocation order with the data that was written
    task automatic check_outputs();
        wb_pkg::rob_id_t wid;
        for (int l = 0; l < 2; l++) begin
            if (retire[l].valid) begin
                if (l == 1 && !retire[0].valid) begin
                    other_errs++;
                    $display("retire lane 1 valid without lane 0 at %0t", $time);
                end
                if (alloc_q.size() == 0) begin
                    other_errs++;
                    $display("retire on lane %0d at %0t with nothing outstanding", l, $time);
                end else begin
                    wid = alloc_q.pop_front();
                    if (retire[l].wid !== wid)
                        report_mismatch($sformatf("retire_o[%0d].wid", l), wid, retire[l].wid);
                    if (!written[wid]) begin
                        other_errs++;
                        $display("entry %0d retired at %0t before its writeback", wid, $time);
                    end
                    if (retire[l].data !== exp_data[wid])
                        report_mismatch($sformatf("retire_o[%0d].data", l), exp_data[wid],
                                        retire[l].data);
                    written[wid] = 1'b0;
                    retired++;
                end
            end
        end
        if (alloc_ready !== (alloc_q.size() != wb_pkg::ROB_DEPTH))
            report_mismatch("alloc_ready_o", alloc_q.size() != wb_pkg::ROB_DEPTH, alloc_ready);
        if (alloc_wid !== tail)
            report_mismatch("alloc_wid_o", tail, alloc_wid);
        for (int p = 0; p < PORTS; p++) begin
            if (ready[p] !== exp_ready[p])
                report_mismatch($sformatf("ready_o[%0d]", p), exp_ready[p], ready[p]);
            if (ready[p] === 1'b0)
                stalls++;
        end
    endtask

    // called on the falling edge, checks what the last rising edge produced and drives the next
    task automatic apply_row(input row_t row);
        int                       idx;
        logic                     refused;
        wb_pkg::cdb_t [PORTS-1:0] req;
        check_outputs();
        for (int p = 0; p < PORTS; p++) begin
            if (drv[p].valid && take[p]) begin
                written[drv[p].wid] = 1'b1;
                drv[p].valid        = 1'b0;
            end
        end
        for (int p = 0; p < PORTS; p++) begin
            if (!drv[p].valid && row.vld[p] && pending.size() != 0) begin
                idx          = row.off[p] % pending.size();
                drv[p].wid   = pending[idx];
                drv[p].data  = $urandom;
                drv[p].valid = 1'b1;
                pending.delete(idx);
                exp_data[drv[p].wid] = drv[p].data;
            end
        end
        alloc = row.alloc;
        if (row.alloc && alloc_q.size() != wb_pkg::ROB_DEPTH) begin
            alloc_q.push_back(tail);
            pending.push_back(tail);
            written[tail] = 1'b0;
            tail          = tail + 1'b1;
        end
        cdb = drv;
        // a refused writeback competes again before the port's next one
        for (int p = 0; p < PORTS; p++) begin
            req[p] = held[p].valid ? held[p] : drv[p];
        end
        // a port loses its bank to any lower numbered port aiming at the same bank
        for (int p = 0; p < PORTS; p++) begin
            refused = 1'b0;
            for (int q = 0; q < p; q++) begin
                if (req[q].valid && req[q].wid[0] == req[p].wid[0])
                    refused = 1'b1;
            end
            take[p]      = drv[p].valid && ready[p];
            held[p]      = (req[p].valid && refused) ? req[p] : '0;
            exp_ready[p] = !held[p].valid;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("timeout after %0d cycles, %0d entries not retired", cycles,
                         alloc_q.size());
                $display("value errors %0d, other errors %0d", value_errs, other_errs + 1);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        cdb       = '0;
        drv       = '0;
        held      = '0;
        alloc     = 1'b0;
        take      = '0;
        exp_ready = '1;
        written   = '0;
        tail      = '0;
        for (int r = 0; r < TBL_LEN; r++) begin
            tbl[r] = (r < DIR_LEN) ? directed_row(r) : random_row();
        end
        @(posedge rst_n);
        @(negedge clk);
        if (ready !== '1)
            report_mismatch("ready_o", 4'hf, ready);
        if (retire[0].valid !== 1'b0 || retire[1].valid !== 1'b0)
            report_mismatch("retire_o valid", 2'b00, {retire[1].valid, retire[0].valid});
        for (int r = 0; r < TBL_LEN; r++) begin
            apply_row(tbl[r]);
            @(negedge clk);
        end
        // hand out every remaining writeback until the buffer is empty
        while (alloc_q.size() != 0) begin
            apply_row(13'b0_1111_00000000);
            @(negedge clk);
        end
        repeat (4) begin
            apply_row('0);
            @(negedge clk);
        end
        if (stalls == 0) begin
            other_errs++;
            $display("no port was ever stalled by arbitration during the run");
        end
        $display("value errors %0d, other errors %0d, retired %0d, stalls %0d",
                 value_errs, other_errs, retired, stalls);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- wb_top.f
common/wb_pkg.sv
common/rob_pkg.sv
hw/cdb_arb/cdb_arb.sv
hw/rob/rob_bank.sv
hw/rob/rob_commit.sv
hw/wb_top.sv
test/clk_gen.sv
test/wb_tb.sv

//--- Bender.yml
package:
  name: wb_top

sources:
  - common/wb_pkg.sv
  - common/rob_pkg.sv
  - hw/cdb_arb/cdb_arb.sv
  - hw/rob/rob_bank.sv
  - hw/rob/rob_commit.sv
  - hw/wb_top.sv
  - target: test
    files:
      - test/clk_gen.sv
      - test/wb_tb.sv
